/* list.f */
common/heartPkg.sv
hw/sampleReceiver.sv
filter/firFilter.sv
peakDetect/peakDetector.sv
hw/dacSerializer.sv
hw/rateCounter.sv
display/rateDisplay.sv
hw/heartMonitor.sv
verification/heartMonitorTb.sv

/* Bender.yml */
package:
  name: heart_monitor

sources:
  - common/heartPkg.sv
  - hw/sampleReceiver.sv
  - filter/firFilter.sv
  - peakDetect/peakDetector.sv
  - hw/dacSerializer.sv
  - hw/rateCounter.sv
  - display/rateDisplay.sv
  - hw/heartMonitor.sv
  - target: test
    files:
      - verification/heartMonitorTb.sv

/* verification/heartMonitorTb.sv */
//################################################
// heart monitor testbench
//################################################
`timescale 1ns/1ps

module heartMonitorTb;
	import heartPkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	// one rate window spans the dc phase
	localparam int WINDOW_CYCLES = 40 * FRAME_BITS;
	localparam int REFRESH_CYCLES = 50;
	localparam int RATE_SCALE = 6;
	// stimulus lengths in frames
	localparam int DC_FRAMES = 40;
	localparam int TRI_PERIOD = 80;
	localparam int TRI_PERIODS = 4;
	localparam int TOTAL_FRAMES = DC_FRAMES + TRI_PERIOD * TRI_PERIODS;
	localparam int FIR_TAPS = 31;
	// dc gain is the coefficient sum over 1024
	localparam int DC_LEVEL = 500;
	localparam int COEF_SUM = 1028;
	localparam int DC_BYTE = ((COEF_SUM * DC_LEVEL) >> 10) % 256;
	// one beat either side of window samples over the period
	// bounds multiplied by the triangle period
	localparam int WINDOW_SAMPLES = WINDOW_CYCLES / FRAME_BITS;
	localparam int RATE_LOW = (WINDOW_SAMPLES - TRI_PERIOD) * RATE_SCALE;
	localparam int RATE_HIGH = (WINDOW_SAMPLES + TRI_PERIOD) * RATE_SCALE;
	localparam logic [SEG_WIDTH-1:0] SEG_ZERO = 7'b100_0000;

	logic                 sck;
	logic                 reset;
	logic                 sdo;
	logic                 dacData;
	logic                 dacLoad;
	logic                 peakLed;
	logic [SEG_WIDTH-1:0] segShared;
	logic [SEG_WIDTH-1:0] segMiddle;
	logic                 digitSelLow;
	logic                 digitSelHigh;

	integer      seed = 32'hf5e65722;
	int          errorCount = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          testErrorBase = 0;
	int          riseCount = 0;
	logic        ledPrev = 1'b0;
	logic        dcPhase = 1'b0;
	logic        triPhase = 1'b0;
	// dac monitor state
	logic [10:0] dacHist = '0;
	logic [10:0] dacWord = '0;
	logic        wordReady = 1'b0;
	int          wordIndex = 0;
	// display monitor state
	int          digit0 = 0;
	int          digit1 = 0;
	int          digit2 = 0;
	int          shownRate;
	logic        selPrev = 1'b0;
	int          cyclesSinceToggle = 0;
	int          togglesSeen = 0;

	heartMonitor #(
		.WINDOW_CYCLES  (WINDOW_CYCLES),
		.REFRESH_CYCLES (REFRESH_CYCLES),
		.RATE_SCALE     (RATE_SCALE)
	) uut (.sck, .reset, .sdo, .dacData, .dacLoad, .peakLed, .segShared, .segMiddle,
		.digitSelLow, .digitSelHigh);

	initial
	begin
		sck = 1'b0;
		forever #(CLK_PERIOD / 2) sck = ~sck;
	end

	task automatic reportMismatch(input string name, input int expected, input int actual);
		$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("failure at %0t: %s", $time, what);
		errorCount++;
	endtask

	task automatic finishTest(input string name);
		$display("test %s finished with %0d errors", name, errorCount - testErrorBase);
		testsRun++;
		if (errorCount != testErrorBase)
			testsFailed++;
		testErrorBase = errorCount;
	endtask

	// decode of active-low segments with g as msb
	// unknown patterns map to 99
	function automatic int segToDigit(input logic [SEG_WIDTH-1:0] seg);
		case (seg)
			7'b100_0000: return 0;
			7'b111_1001: return 1;
			7'b010_0100: return 2;
			7'b011_0000: return 3;
			7'b001_1001: return 4;
			7'b001_0010: return 5;
			7'b000_0010: return 6;
			7'b111_1000: return 7;
			7'b000_0000: return 8;
			7'b001_1000: return 9;
			7'b000_1000: return 10;
			7'b000_0011: return 11;
			7'b010_0111: return 12;
			7'b010_0001: return 13;
			7'b000_0110: return 14;
			7'b000_1110: return 15;
			default: return 99;
		endcase
	endfunction

	// rises 2 per sample for half a period then falls back
	function automatic int triangleValue(input int n);
		int pos;
		pos = n % TRI_PERIOD;
		if (pos < TRI_PERIOD / 2)
			return DC_LEVEL + 2 * pos;
		return DC_LEVEL + 2 * (TRI_PERIOD - pos);
	endfunction

	// one spi frame msb first with random upper bits
	// led rises are counted along the way
	task automatic sendFrame(input logic [SAMPLE_WIDTH-1:0] value);
		logic [FRAME_BITS-1:0] frameWord;
		int                    randBits;
		randBits = $random(seed);
		frameWord = {randBits[5:0], value};
		for (int i = FRAME_BITS - 1; i >= 0; i--)
		begin
			sdo <= frameWord[i];
			@(posedge sck);
			if (peakLed && !ledPrev)
				riseCount++;
			ledPrev = peakLed;
		end
	endtask

	// dac word rebuild and display decode
	always @(posedge sck)
	begin
		dacHist <= {dacHist[9:0], dacData};
		wordReady <= !dacLoad;
		if (!dacLoad)
		begin
			dacWord <= dacHist;
			wordIndex <= wordIndex + 1;
		end
		if (digitSelLow)
			digit0 <= segToDigit(segShared);
		else
			digit2 <= segToDigit(segShared);
		digit1 <= segToDigit(segMiddle);
		selPrev <= digitSelLow;
		if (digitSelLow != selPrev)
		begin
			cyclesSinceToggle <= 1;
			togglesSeen <= togglesSeen + 1;
		end
		else
			cyclesSinceToggle <= cyclesSinceToggle + 1;
	end

	assign shownRate = digit2 * 256 + digit1 * 16 + digit0;

	// reset values hold until one cycle past release
	assert property (@(posedge sck) (reset || $fell(reset)) |-> dacLoad)
		else reportMismatch("dacLoad", 1, $sampled(dacLoad));
	assert property (@(posedge sck) (reset || $fell(reset)) |-> !peakLed)
		else reportMismatch("peakLed", 0, $sampled(peakLed));
	assert property (@(posedge sck) (reset || $fell(reset)) |-> !digitSelLow)
		else reportMismatch("digitSelLow", 0, $sampled(digitSelLow));
	assert property (@(posedge sck) (reset || $fell(reset)) |-> segShared == SEG_ZERO)
		else reportMismatch("segShared", SEG_ZERO, $sampled(segShared));
	assert property (@(posedge sck) (reset || $fell(reset)) |-> segMiddle == SEG_ZERO)
		else reportMismatch("segMiddle", SEG_ZERO, $sampled(segMiddle));

	// one low cycle per word and one word per frame
	assert property (@(posedge sck) disable iff (reset)
		$fell(dacLoad) |=> dacLoad [*(FRAME_BITS - 1)] ##1 !dacLoad)
		else reportFailure("dacLoad low pulse is not one cycle once per frame");
	assert property (@(posedge sck) wordReady |-> dacWord[10:8] == 3'b000)
		else reportMismatch("dacWord[10:8]", 0, $sampled(dacWord[10:8]));
	// words past the delay line length see only the dc level
	assert property (@(posedge sck)
		wordReady && wordIndex > FIR_TAPS && wordIndex <= DC_FRAMES |-> dacWord[7:0] == DC_BYTE)
		else reportMismatch("dacWord[7:0]", DC_BYTE, $sampled(dacWord[7:0]));

	assert property (@(posedge sck) digitSelHigh == !digitSelLow)
		else reportMismatch("digitSelHigh", !$sampled(digitSelLow), $sampled(digitSelHigh));
	// first toggle has no reference point
	assert property (@(posedge sck) disable iff (reset)
		(digitSelLow != selPrev) && togglesSeen > 0 |-> cyclesSinceToggle == REFRESH_CYCLES)
		else reportMismatch("digitSelLow interval", REFRESH_CYCLES, $sampled(cyclesSinceToggle));
	assert property (@(posedge sck) disable iff (reset) dcPhase |-> shownRate == 0)
		else reportMismatch("shownRate", 0, $sampled(shownRate));
	assert property (@(posedge sck) disable iff (reset)
		triPhase |-> (shownRate % RATE_SCALE == 0) && (shownRate * TRI_PERIOD >= RATE_LOW)
			&& (shownRate * TRI_PERIOD <= RATE_HIGH))
		else reportFailure($sformatf("shown rate %0d is off the beat rate", $sampled(shownRate)));

	initial
	begin
		reset = 1'b1;
		sdo = 1'b0;
		repeat (RESET_CYCLES) @(posedge sck);
		reset <= 1'b0;
		finishTest("reset state");

		// constant input with the first frame right after release
		dcPhase = 1'b1;
		repeat (DC_FRAMES) sendFrame(SAMPLE_WIDTH'(DC_LEVEL));
		assert (riseCount == 0)
			else reportMismatch("peakLed rises with constant input", 0, riseCount);
		finishTest("dac framing and filter dc response");

		triPhase = 1'b1;
		for (int p = 0; p < TRI_PERIODS; p++)
		begin
			riseCount = 0;
			for (int n = 0; n < TRI_PERIOD; n++)
			begin
				sendFrame(SAMPLE_WIDTH'(triangleValue(n)));
				// dc window result stays on display until the next window closes
				if (p == 0 && n == WINDOW_SAMPLES - 1)
					dcPhase = 1'b0;
			end
			// first period still carries the filter start-up
			if (p > 0)
				assert (riseCount == 1)
					else reportMismatch("peakLed rises per period", 1, riseCount);
		end
		triPhase = 1'b0;
		finishTest("peak detection, rate and display");

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog over the whole stimulus length plus margin
	initial
	begin
		repeat (RESET_CYCLES + TOTAL_FRAMES * FRAME_BITS + 400) @(posedge sck);
		$display("watchdog expired before the stimulus finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hw/heartMonitor.sv */
//################################################
// heart rate monitor top
//################################################
`timescale 1ns/1ps

module heartMonitor #(
	parameter int WINDOW_CYCLES = 400_000_000,
	parameter int REFRESH_CYCLES = 250_000,
	parameter int RATE_SCALE = 6
) (
	input  logic                          sck,
	input  logic                          reset,
	input  logic                          sdo,
	output logic                          dacData,
	output logic                          dacLoad,
	output logic                          peakLed,
	output logic [heartPkg::SEG_WIDTH-1:0] segShared,
	output logic [heartPkg::SEG_WIDTH-1:0] segMiddle,
	output logic                          digitSelLow,
	output logic                          digitSelHigh
);
	import heartPkg::*;

	sampleT                sample;
	logic                  sampleValid;
	sampleT                filtered;
	logic                  filteredValid;
	logic                  peakPulse;
	logic [RATE_WIDTH-1:0] heartRate;

	// spi in, one sample per frame
	sampleReceiver rx (.sck, .reset, .sdo, .sample, .sampleValid);

	firFilter fir (.sck, .reset, .sample, .sampleValid, .filtered, .filteredValid);

	// filtered value fans out to dac and peak finder
	dacSerializer dac (.sck, .reset, .filtered, .filteredValid, .dacData, .dacLoad);

	peakDetector peaks (.sck, .reset, .filtered, .filteredValid, .peakPulse, .peakLed);

	rateCounter #(
		.WINDOW_CYCLES (WINDOW_CYCLES),
		.RATE_SCALE    (RATE_SCALE)
	) rate (.sck, .reset, .peakPulse, .heartRate);

	rateDisplay #(
		.REFRESH_CYCLES (REFRESH_CYCLES)
	) display (.sck, .reset, .heartRate, .segShared, .segMiddle, .digitSelLow, .digitSelHigh);

endmodule

/* display/rateDisplay.sv */
//################################################
// rate display driver
//################################################
`timescale 1ns/1ps

module rateDisplay #(
	parameter int REFRESH_CYCLES = 250_000
) (
	input  logic                           sck,
	input  logic                           reset,
	input  logic [heartPkg::RATE_WIDTH-1:0] heartRate,
	output logic [heartPkg::SEG_WIDTH-1:0]  segShared,
	output logic [heartPkg::SEG_WIDTH-1:0]  segMiddle,
	output logic                           digitSelLow,
	output logic                           digitSelHigh
);
	import heartPkg::*;

	localparam int REFRESH_WIDTH = $clog2(REFRESH_CYCLES);

	logic [REFRESH_WIDTH-1:0] refreshCount;
	logic [3:0]               sharedNibble;

	// active-low hex patterns, segment g is the msb
	function automatic logic [SEG_WIDTH-1:0] hexSeg(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b010_0111;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	// outer digits take turns on the shared segment bus
	assign sharedNibble = digitSelLow ? heartRate[3:0] : heartRate[11:8];
	assign segShared = hexSeg(sharedNibble);
	assign segMiddle = hexSeg(heartRate[7:4]);
	assign digitSelHigh = ~digitSelLow;

	// refresh timer
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			refreshCount <= '0;
			digitSelLow <= 1'b0;
		end
		else if (refreshCount == REFRESH_WIDTH'(REFRESH_CYCLES - 1))
		begin
			refreshCount <= '0;
			digitSelLow <= ~digitSelLow;
		end
		else
			refreshCount <= refreshCount + 1'b1;
	end

endmodule

/* hw/rateCounter.sv */
//################################################
// windowed beat counter
//################################################
`timescale 1ns/1ps

module rateCounter #(
	parameter int WINDOW_CYCLES = 400_000_000,
	parameter int RATE_SCALE = 6
) (
	input  logic                          sck,
	input  logic                          reset,
	input  logic                          peakPulse,
	output logic [heartPkg::RATE_WIDTH-1:0] heartRate
);
	import heartPkg::*;

	localparam int CYCLE_WIDTH = $clog2(WINDOW_CYCLES);
	// largest count whose scaled value still fits the rate
	localparam int PEAK_MAX = (2 ** RATE_WIDTH - 1) / RATE_SCALE;

	logic [CYCLE_WIDTH-1:0] cycleCount;
	logic [RATE_WIDTH-1:0]  peakCount;
	logic                   windowEnd;

	assign windowEnd = (cycleCount == CYCLE_WIDTH'(WINDOW_CYCLES - 1));

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			cycleCount <= '0;
			peakCount <= '0;
			heartRate <= '0;
		end
		else if (windowEnd)
		begin
			cycleCount <= '0;
			heartRate <= RATE_WIDTH'(peakCount * RATE_SCALE);
			// pulse on the boundary opens the next window
			peakCount <= RATE_WIDTH'(peakPulse);
		end
		else
		begin
			cycleCount <= cycleCount + 1'b1;
			if (peakPulse && peakCount != RATE_WIDTH'(PEAK_MAX))
				peakCount <= peakCount + 1'b1;
		end
	end

endmodule

/* hw/dacSerializer.sv */
//################################################
// serial dac word output
//################################################
`timescale 1ns/1ps

module dacSerializer (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT filtered,
	input  logic             filteredValid,
	output logic             dacData,
	output logic             dacLoad
);
	import heartPkg::*;

	localparam int BIT_WIDTH = $clog2(DAC_WORD_BITS);

	dacPhaseT                 phase;
	logic [DAC_WORD_BITS-1:0] shiftReg;
	logic [BIT_WIDTH-1:0]     bitCount;

	// msb of the word goes out first
	assign dacData = shiftReg[DAC_WORD_BITS-1];

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			phase <= dacIdle;
			shiftReg <= '0;
			bitCount <= '0;
			dacLoad <= 1'b1;
		end
		else
		begin
			case (phase)
				dacIdle:
				begin
					if (filteredValid)
					begin
						// address 00, range 0, then data byte
						shiftReg <= {2'b00, 1'b0, filtered[7:0]};
						bitCount <= '0;
						phase <= dacShift;
					end
				end
				dacShift:
				begin
					shiftReg <= {shiftReg[DAC_WORD_BITS-2:0], 1'b0};
					bitCount <= bitCount + 1'b1;
					if (bitCount == BIT_WIDTH'(DAC_WORD_BITS - 1))
					begin
						// latch pulse right after the last bit
						dacLoad <= 1'b0;
						phase <= dacStrobe;
					end
				end
				dacStrobe:
				begin
					dacLoad <= 1'b1;
					phase <= dacRelease;
				end
				dacRelease:
					phase <= dacIdle;
				default:
					phase <= dacIdle;
			endcase
		end
	end

	// a new word may only start once the previous one is done
	assert property (@(posedge sck) disable iff (reset) filteredValid |-> phase == dacIdle);

endmodule

/* peakDetect/peakDetector.sv */
//################################################
// slope-window peak detector
//################################################
`timescale 1ns/1ps

module peakDetector #(
	parameter int WINDOW_BITS = 64,
	parameter int LEFT_MAX = 20,
	parameter int RIGHT_MIN = 16,
	parameter int HOLD_SAMPLES = 63
) (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT filtered,
	input  logic             filteredValid,
	output logic             peakPulse,
	output logic             peakLed
);
	import heartPkg::*;

	localparam int HALF = WINDOW_BITS / 2;
	localparam int SUM_WIDTH = $clog2(HALF + 1);
	localparam int HOLD_WIDTH = $clog2(HOLD_SAMPLES + 1);

	peakStateT               state;
	sampleT                  prevSample;
	logic [WINDOW_BITS-1:0]  slopeHist;
	logic [SUM_WIDTH-1:0]    leftSum;
	logic [SUM_WIDTH-1:0]    rightSum;
	logic [HOLD_WIDTH-1:0]   holdCount;
	logic                    slopeBit;
	logic                    peakFound;

	// 0 while rising, 1 when flat or falling
	assign slopeBit = !(filtered > prevSample);
	// older half mostly rising, newer half mostly falling
	assign peakFound = (leftSum <= SUM_WIDTH'(LEFT_MAX)) && (rightSum >= SUM_WIDTH'(RIGHT_MIN));
	assign peakLed = (state == pkHold);

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			state <= pkSearch;
			prevSample <= '0;
			slopeHist <= '1;
			leftSum <= SUM_WIDTH'(HALF);
			rightSum <= SUM_WIDTH'(HALF);
			holdCount <= '0;
			peakPulse <= 1'b0;
		end
		else
		begin
			peakPulse <= 1'b0;
			if (filteredValid)
			begin
				prevSample <= filtered;
				slopeHist <= {slopeHist[WINDOW_BITS-2:0], slopeBit};
				// bit crossing the midpoint moves from right sum to left sum
				rightSum <= rightSum + SUM_WIDTH'(slopeBit) - SUM_WIDTH'(slopeHist[HALF-1]);
				leftSum <= leftSum + SUM_WIDTH'(slopeHist[HALF-1])
					- SUM_WIDTH'(slopeHist[WINDOW_BITS-1]);
				case (state)
					pkSearch:
					begin
						if (peakFound)
						begin
							peakPulse <= 1'b1;
							holdCount <= '0;
							state <= pkHold;
						end
					end
					pkHold:
					begin
						// hold-off masks the falling edge of the same beat
						if (holdCount == HOLD_WIDTH'(HOLD_SAMPLES - 1))
							state <= pkSearch;
						holdCount <= holdCount + 1'b1;
					end
					default:
						state <= pkSearch;
				endcase
			end
		end
	end

	assert property (@(posedge sck) disable iff (reset)
		peakPulse |-> ($past(state) == pkSearch) && (state == pkHold));

endmodule

/* filter/firFilter.sv */
//################################################
// symmetric 31-tap fir low-pass
//################################################
`timescale 1ns/1ps

module firFilter (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT sample,
	input  logic             sampleValid,
	output heartPkg::sampleT filtered,
	output logic             filteredValid
);
	import heartPkg::*;

	localparam int FIR_TAPS = 2 * FIR_HALF_TAPS - 1;

	sampleT                   delayLine [FIR_TAPS-1];
	sampleT                   taps [FIR_TAPS];
	logic [FIR_ACC_WIDTH-1:0] sumNext;
	logic [FIR_ACC_WIDTH-1:0] sumReg;
	logic                     sumValid;

	// tap 0 is the incoming sample, the rest come from the delay line
	always_comb
	begin
		taps[0] = sample;
		for (int k = 1; k < FIR_TAPS; k++)
			taps[k] = delayLine[k-1];
	end

	// fold symmetric taps, one multiply per coefficient
	always_comb
	begin : sumTree
		logic [FIR_ACC_WIDTH-1:0] acc;
		logic [SAMPLE_WIDTH:0]    pairSum;
		acc = '0;
		for (int i = 0; i < FIR_HALF_TAPS - 1; i++)
		begin
			pairSum = {1'b0, taps[i]} + {1'b0, taps[FIR_TAPS-1-i]};
			acc = acc + FIR_ACC_WIDTH'(FIR_COEFFS[i]) * FIR_ACC_WIDTH'(pairSum);
		end
		// centre tap has no partner
		acc = acc + FIR_ACC_WIDTH'(FIR_COEFFS[FIR_HALF_TAPS-1])
			* FIR_ACC_WIDTH'(taps[FIR_HALF_TAPS-1]);
		sumNext = acc;
	end

	// delay line, zero after reset
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			for (int k = 0; k < FIR_TAPS - 1; k++)
				delayLine[k] <= '0;
		end
		else if (sampleValid)
		begin
			delayLine[0] <= sample;
			for (int k = 1; k < FIR_TAPS - 1; k++)
				delayLine[k] <= delayLine[k-1];
		end
	end

	// valid pipe, sum stage then scale stage
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			sumValid <= 1'b0;
			filteredValid <= 1'b0;
		end
		else
		begin
			sumValid <= sampleValid;
			filteredValid <= sumValid;
		end
	end

	always_ff @(posedge sck)
	begin
		if (sampleValid)
			sumReg <= sumNext;
		// drop the 1024 scale
		if (sumValid)
			filtered <= sumReg[FIR_SHIFT +: SAMPLE_WIDTH];
	end

endmodule

/* hw/sampleReceiver.sv */
//################################################
// spi sample receiver
//################################################
`timescale 1ns/1ps

module sampleReceiver (
	input  logic            sck,
	input  logic            reset,
	input  logic            sdo,
	output heartPkg::sampleT sample,
	output logic            sampleValid
);
	import heartPkg::*;

	localparam int CNT_WIDTH = $clog2(FRAME_BITS);

	logic [CNT_WIDTH-1:0]  bitCount;
	logic [FRAME_BITS-1:0] shiftReg;
	logic [FRAME_BITS-1:0] frameNext;
	logic                  frameEnd;

	// msb first, the last bit joins straight from sdo
	assign frameNext = {shiftReg[FRAME_BITS-2:0], sdo};
	assign frameEnd = (bitCount == CNT_WIDTH'(FRAME_BITS - 1));

	// frame counter, wraps every 16 cycles
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			bitCount <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			bitCount <= bitCount + 1'b1;
			sampleValid <= frameEnd;
		end
	end

	// shifter and sample latch
	always_ff @(posedge sck)
	begin
		shiftReg <= frameNext;
		if (frameEnd)
			sample <= frameNext[SAMPLE_WIDTH-1:0];
	end

	// strobe is a single pulse per frame
	assert property (@(posedge sck) disable iff (reset) sampleValid |=> !sampleValid);

endmodule

/* common/heartPkg.sv */
//################################################
// heart monitor shared definitions
//################################################

package heartPkg;

	// spi frame and sample sizes
	localparam int FRAME_BITS = 16;
	localparam int SAMPLE_WIDTH = 10;

	typedef logic [SAMPLE_WIDTH-1:0] sampleT;

	// low-pass fir, half of a symmetric 31-tap response
	localparam int FIR_HALF_TAPS = 16;
	// scaled by 1024, coefficients sum to 1028
	localparam int FIR_COEFFS [FIR_HALF_TAPS] = '{
		3, 4, 6, 8, 12, 17, 23, 29, 36, 43, 50, 56, 61, 65, 67, 68
	};
	localparam int FIR_SHIFT = 10;
	localparam int FIR_ACC_WIDTH = 20;

	// dac word: address, range, data byte
	localparam int DAC_WORD_BITS = 11;

	localparam int RATE_WIDTH = 12;
	localparam int SEG_WIDTH = 7;

	typedef enum logic [1:0] {dacIdle, dacShift, dacStrobe, dacRelease} dacPhaseT;

	typedef enum logic {pkSearch, pkHold} peakStateT;

endpackage
